// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_elink_cfg
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_if
   import emesh_pkg::*;
#(
   parameter logic [ID_W-1:0] ID = 12'h999,
   parameter bit              RX = 1'b0
)
(
   input  wire logic          clk,
   input  wire logic          nreset,
   input  wire logic          in_valid,
   input  wire emesh_packet_t in_packet,
   output logic               in_ready,
   output logic               out_valid,
   output emesh_packet_t      out_packet,
   input  wire logic          out_ready,
   output mi_bus_t            mi,
   output logic               cfg_en,
   output logic               dma_en,
   output logic               mmu_en,
   input  wire logic [63:0]   cfg_dout,
   input  wire logic [63:0]   dma_dout,
   input  wire logic [63:0]   mmu_dout
);

   logic          xfer;
   logic          match;
   logic [3:0]    group;
   logic [2:0]    blk;
   logic          cfg_sel;
   logic          dma_sel;
   logic          mmu_sel;
   logic          local_sel;
   logic          rd;
   logic          fwd;
   logic [63:0]   dout;
   emesh_packet_t reply;

   // single output slot, refilled in the cycle it drains
   assign in_ready = !out_valid || out_ready;
   assign xfer     = in_valid && in_ready;

   assign match = in_packet.dstaddr[31:ID_LSB] == ID;
   assign group = in_packet.dstaddr[GRP_MSB:GRP_LSB];
   assign blk   = in_packet.dstaddr[BLK_MSB:BLK_LSB];

   assign cfg_sel = match && group == EGROUP_MMR && blk == {CFG_BLK_HI, RX};
   assign dma_sel = match && group == EGROUP_MMR && blk == DMA_BLK &&
                    in_packet.dstaddr[DMA_RX_BIT] == RX;
   assign mmu_sel = match && group == EGROUP_MMU &&
                    in_packet.dstaddr[MMU_RX_BIT] == RX;

   assign local_sel = cfg_sel || dma_sel || mmu_sel;
   assign rd        = local_sel && !in_packet.write;

   // our register groups but no block here, pass it along
   assign fwd = match && !local_sel &&
                (group == EGROUP_RR || group == EGROUP_MMR || group == EGROUP_MMU);

   // enables only on an accepted packet so stalls write nothing
   assign cfg_en = cfg_sel && xfer;
   assign dma_en = dma_sel && xfer;
   assign mmu_en = mmu_sel && xfer;

   assign mi.we   = in_packet.write;
   assign mi.addr = in_packet.dstaddr[14:0];
   assign mi.din  = {in_packet.srcaddr, in_packet.data};

   // unselected blocks drive zero
   assign dout = cfg_dout | dma_dout | mmu_dout;

   always_comb
   begin
      reply          = in_packet;
      reply.write    = 1'b1;
      reply.dstaddr  = in_packet.srcaddr;
      reply.srcaddr  = dout[63:32];
      reply.data     = dout[31:0];
      reply.pad      = 1'b0;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         out_valid <= 1'b0;
      else if (xfer)
         out_valid <= rd || fwd;
      else if (out_ready)
         out_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (xfer)
         out_packet <= fwd ? in_packet : reply;
   end

   // decode must never hit two blocks at once
   assert property (@(posedge clk) disable iff (!nreset)
      $onehot0({cfg_en, dma_en, mmu_en}));

   // held output survives a stall unchanged
   assert property (@(posedge clk) disable iff (!nreset)
      out_valid && !out_ready |=> out_valid && $stable(out_packet));

endmodule

`default_nettype wire

// File: cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_regs
   import emesh_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        nreset,
   input  wire logic        en,
   input  wire mi_bus_t     mi,
   output logic [63:0]      dout,
   output logic [31:0]      link_ctrl
);

   localparam int NWORDS = 8;

   logic [31:0] regs [NWORDS];
   logic [2:0]  idx;
   logic        wr;

   assign idx = mi.addr[REG_IDX_MSB:REG_IDX_LSB];
   assign wr  = en && mi.we;

   // words written from the low half of din
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < NWORDS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr)
      begin
         regs[idx] <= mi.din[31:0];
      end
   end

   // readback, upper half always zero
   always_comb
   begin
      if (en)
         dout = {32'h0, regs[idx]};
      else
         dout = '0;
   end

   // word 0 is the link control word
   assign link_ctrl = regs[0];

   // readback OR in cfg_if relies on idle blocks being quiet
   assert property (@(posedge clk) disable iff (!nreset)
      !en |-> dout == '0);

endmodule

`default_nettype wire

// File: cfg_stim.txt
// first value is the record count, then one record per line:
// w dm cm dstaddr data srcaddr  out w dm cm dstaddr data srcaddr  link_ctrl dma_ctrl
14
// cfg writes and readback
1 0 0 999F0200 11223344 00000000  0 0 0 0 00000000 00000000 00000000  11223344 00000000
1 1 2 999F020C CAFE0003 00000000  0 0 0 0 00000000 00000000 00000000  11223344 00000000
0 2 5 999F020C 00000000 8000A000  1 1 2 5 8000A000 CAFE0003 00000000  11223344 00000000
0 0 0 999F0200 00000000 80001234  1 1 0 0 80001234 11223344 00000000  11223344 00000000
// dma writes and readback
1 0 0 999F0500 D0D0D0D0 00000000  0 0 0 0 00000000 00000000 00000000  11223344 D0D0D0D0
1 0 0 999F051C 07070707 00000000  0 0 0 0 00000000 00000000 00000000  11223344 D0D0D0D0
0 0 3 999F051C 00000000 8100B000  1 1 0 3 8100B000 07070707 00000000  11223344 D0D0D0D0
// mmu entry 5, full 64-bit din
1 0 0 999E0028 89ABCDEF 01234567  0 0 0 0 00000000 00000000 00000000  11223344 D0D0D0D0
0 0 0 999E0028 00000000 8200C000  1 1 0 0 8200C000 89ABCDEF 01234567  11223344 D0D0D0D0
// wrong id and foreign group are dropped
1 0 0 123F0200 FFFFFFFF 00000000  0 0 0 0 00000000 00000000 00000000  11223344 D0D0D0D0
0 0 0 99900200 00000000 80000000  0 0 0 0 00000000 00000000 00000000  11223344 D0D0D0D0
// rx=1 blocks, rr group and unselected mmr are forwarded as copies
1 0 0 999F0300 EEEEEEEE 00000000  1 1 0 0 999F0300 EEEEEEEE 00000000  11223344 D0D0D0D0
0 0 0 999E8028 00000000 83000000  1 0 0 0 999E8028 00000000 83000000  11223344 D0D0D0D0
0 1 4 999D0040 00000000 84000000  1 0 1 4 999D0040 00000000 84000000  11223344 D0D0D0D0
1 2 9 999D0100 5A5A5A5A 84000004  1 1 2 9 999D0100 5A5A5A5A 84000004  11223344 D0D0D0D0
1 0 0 999F0520 BADBAD00 00000000  1 1 0 0 999F0520 BADBAD00 00000000  11223344 D0D0D0D0
// rewrite then read, unwritten entry reads zero
1 0 0 999F0200 55AA55AA 00000000  0 0 0 0 00000000 00000000 00000000  55AA55AA D0D0D0D0
0 0 0 999F0200 00000000 86000000  1 1 0 0 86000000 55AA55AA 00000000  55AA55AA D0D0D0D0
0 0 0 999E0000 00000000 87000000  1 1 0 0 87000000 00000000 00000000  55AA55AA D0D0D0D0
0 3 1 999F0500 00000000 88000000  1 1 3 1 88000000 D0D0D0D0 00000000  55AA55AA D0D0D0D0

// File: dma_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dma_regs
   import emesh_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        nreset,
   input  wire logic        en,
   input  wire mi_bus_t     mi,
   output logic [63:0]      dout,
   output logic [31:0]      dma_ctrl
);

   localparam int NWORDS = 8;

   logic [31:0] regs [NWORDS];
   logic [2:0]  idx;

   // word select inside the dma block
   assign idx = mi.addr[REG_IDX_MSB:REG_IDX_LSB];

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < NWORDS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (en && mi.we)
      begin
         regs[idx] <= mi.din[31:0];
      end
   end

   always_comb
   begin
      dout = '0;
      if (en)
         dout[31:0] = regs[idx];
   end

   // dma control word for the engine
   assign dma_ctrl = regs[0];

   assert property (@(posedge clk) disable iff (!nreset)
      !en |-> dout == '0);

endmodule

`default_nettype wire

// File: elink_cfg.sv
`timescale 1ns/100ps
`default_nettype none

module elink_cfg
   import emesh_pkg::*;
#(
   parameter logic [ID_W-1:0] ID = 12'h999,
   parameter bit              RX = 1'b0
)
(
   input  wire logic          clk,
   input  wire logic          nreset,
   input  wire logic          in_valid,
   input  wire emesh_packet_t in_packet,
   output logic               in_ready,
   output logic               out_valid,
   output emesh_packet_t      out_packet,
   input  wire logic          out_ready,
   output logic [31:0]        link_ctrl,
   output logic [31:0]        dma_ctrl
);

   mi_bus_t     mi;
   logic        cfg_en;
   logic        dma_en;
   logic        mmu_en;
   logic [63:0] cfg_dout;
   logic [63:0] dma_dout;
   logic [63:0] mmu_dout;

   // packet decode and reply path
   cfg_if #(
      .ID (ID),
      .RX (RX)
   ) cfg_if_i (
      .clk        (clk),
      .nreset     (nreset),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready),
      .mi         (mi),
      .cfg_en     (cfg_en),
      .dma_en     (dma_en),
      .mmu_en     (mmu_en),
      .cfg_dout   (cfg_dout),
      .dma_dout   (dma_dout),
      .mmu_dout   (mmu_dout)
   );

   cfg_regs cfg_regs_i (
      .clk       (clk),
      .nreset    (nreset),
      .en        (cfg_en),
      .mi        (mi),
      .dout      (cfg_dout),
      .link_ctrl (link_ctrl)
   );

   dma_regs dma_regs_i (
      .clk      (clk),
      .nreset   (nreset),
      .en       (dma_en),
      .mi       (mi),
      .dout     (dma_dout),
      .dma_ctrl (dma_ctrl)
   );

   mmu_table mmu_table_i (
      .clk    (clk),
      .nreset (nreset),
      .en     (mmu_en),
      .mi     (mi),
      .dout   (mmu_dout)
   );

endmodule

`default_nettype wire

// File: emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   // packet and node widths
   localparam int PW   = 104;
   localparam int ID_W = 12;

   // mesh transaction, pad bit at the low end is always zero
   typedef struct packed {
      logic        write;
      logic [1:0]  datamode;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
      logic        pad;
   } emesh_packet_t;

   // register bus shared by all blocks
   typedef struct packed {
      logic        we;
      logic [14:0] addr;
      logic [63:0] din;
   } mi_bus_t;

   // address groups, dstaddr[19:16]
   localparam logic [3:0] EGROUP_MMR = 4'hF;
   localparam logic [3:0] EGROUP_MMU = 4'hE;
   localparam logic [3:0] EGROUP_RR  = 4'hD;

   // destination address fields
   localparam int ID_LSB     = 20;
   localparam int GRP_MSB    = 19;
   localparam int GRP_LSB    = 16;
   localparam int MMU_RX_BIT = 15;
   localparam int BLK_MSB    = 10;
   localparam int BLK_LSB    = 8;
   localparam int DMA_RX_BIT = 5;

   // block codes in dstaddr[10:8]
   localparam logic [1:0] CFG_BLK_HI = 2'b01;
   localparam logic [2:0] DMA_BLK    = 3'h5;

   // word index fields on the register bus
   localparam int REG_IDX_MSB = 4;
   localparam int REG_IDX_LSB = 2;
   localparam int MMU_IDX_MSB = 8;
   localparam int MMU_IDX_LSB = 3;

endpackage

`default_nettype wire

// File: mmu_table.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_table
   import emesh_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        nreset,
   input  wire logic        en,
   input  wire mi_bus_t     mi,
   output logic [63:0]      dout
);

   localparam int NENTRIES = 64;

   logic [63:0] entries [NENTRIES];
   logic [5:0]  idx;

   // 64-bit entries, so word select starts at bit 3
   assign idx = mi.addr[MMU_IDX_MSB:MMU_IDX_LSB];

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < NENTRIES; i++)
         begin
            entries[i] <= '0;
         end
      end
      else if (en && mi.we)
      begin
         entries[idx] <= mi.din;
      end
   end

   // full entry readback, only from stored state
   assign dout = en ? entries[idx] : '0;

   assert property (@(posedge clk) disable iff (!nreset)
      !en |-> dout == '0);

endmodule

`default_nettype wire

// File: tb.f
emesh_pkg.sv
cfg_if.sv
cfg_regs.sv
dma_regs.sv
mmu_table.sv
elink_cfg.sv
tb_clock_gen.sv
tb_elink_cfg.sv

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 16
)
(
   output logic clk,
   output logic nreset
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2) clk = ~clk;
   end

   // release on a falling edge, away from the flops
   initial
   begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb_elink_cfg.sv
`timescale 1ns/100ps
`default_nettype none

module tb_elink_cfg
   import emesh_pkg::*;
();

   localparam int          REC_WORDS = 15;
   localparam int          MAX_RECS  = 64;
   localparam int          TIMEOUT   = 1000;
   localparam logic [31:0] LFSR_SEED = 32'habf41423;

   logic          clk;
   logic          nreset;
   logic          in_valid;
   emesh_packet_t in_packet;
   logic          in_ready;
   logic          out_valid;
   emesh_packet_t out_packet;
   logic          out_ready;
   logic [31:0]   link_ctrl;
   logic [31:0]   dma_ctrl;

   // word 0 is the record count, then REC_WORDS words per record
   logic [31:0]   stim_mem [0:REC_WORDS*MAX_RECS];
   emesh_packet_t expected_q [$];
   int            num_recs;

   tb_clock_gen #(
      .PERIOD_NS    (20),
      .RESET_CYCLES (16)
   ) clock_gen_i (
      .clk    (clk),
      .nreset (nreset)
   );

   elink_cfg #(
      .ID (12'h999),
      .RX (1'b0)
   ) dut_i (
      .clk        (clk),
      .nreset     (nreset),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready),
      .link_ctrl  (link_ctrl),
      .dma_ctrl   (dma_ctrl)
   );

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0])
         next = next ^ 32'h80200003;
      return next;
   endfunction

   // six words starting at base, same layout for request and expected
   function automatic emesh_packet_t packet_from(input int base);
      emesh_packet_t p;
      p.write    = stim_mem[base][0];
      p.datamode = stim_mem[base+1][1:0];
      p.ctrlmode = stim_mem[base+2][3:0];
      p.dstaddr  = stim_mem[base+3];
      p.data     = stim_mem[base+4];
      p.srcaddr  = stim_mem[base+5];
      p.pad      = 1'b0;
      return p;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
   endtask

   // one record, entered and left on a rising edge
   task automatic send_record(input int base);
      emesh_packet_t req;
      int            cycles;
      req = packet_from(base);
      in_valid  <= 1'b1;
      in_packet <= req;
      cycles = 0;
      @(negedge clk);
      while (!in_ready)
      begin
         cycles++;
         assert (cycles < TIMEOUT)
         else
            abort_run("timeout: in_ready stayed low while a packet was offered");
         @(negedge clk);
      end
      // transfer edge
      @(posedge clk);
      in_valid <= 1'b0;
      if (stim_mem[base+6][0])
         expected_q.push_back(packet_from(base + 7));
      @(negedge clk);
      // reply or forward shows up one clock after the transfer
      assert (out_valid == stim_mem[base+6][0])
      else
         report_mismatch($sformatf("out_valid is %b after the transfer, expected %b",
                                   out_valid, stim_mem[base+6][0]));
      assert (link_ctrl == stim_mem[base+13])
      else
         report_mismatch($sformatf("link_ctrl is %h, expected %h",
                                   link_ctrl, stim_mem[base+13]));
      assert (dma_ctrl == stim_mem[base+14])
      else
         report_mismatch($sformatf("dma_ctrl is %h, expected %h",
                                   dma_ctrl, stim_mem[base+14]));
      @(posedge clk);
   endtask

   // random back-pressure, one lfsr bit per cycle
   initial
   begin : stall_driver
      logic [31:0] lfsr;
      out_ready <= 1'b0;
      lfsr = LFSR_SEED;
      forever
      begin
         @(posedge clk);
         out_ready <= !lfsr[0];
         lfsr = lfsr_step(lfsr);
      end
   end

   // compare each output when it transfers
   initial
   begin : output_monitor
      emesh_packet_t exp_pkt;
      forever
      begin
         @(negedge clk);
         if (nreset && out_valid && !out_ready)
         begin
            assert (!in_ready)
            else
               report_mismatch("in_ready is high while the output is stalled");
         end
         if (nreset && out_valid && out_ready)
         begin
            assert (expected_q.size() > 0)
            else
               abort_run("an output packet came out when none was expected");
            exp_pkt = expected_q.pop_front();
            assert (out_packet == exp_pkt)
            else
               report_mismatch($sformatf("out_packet is %h, expected %h",
                                         out_packet, exp_pkt));
         end
      end
   end

   initial
   begin : main_sequence
      int cycles;
      in_valid  <= 1'b0;
      in_packet <= '0;
      $readmemh("cfg_stim.txt", stim_mem);
      num_recs = stim_mem[0];
      assert (num_recs > 0 && num_recs <= MAX_RECS)
      else
         abort_run("the stimulus file cfg_stim.txt is missing or has a bad record count");

      cycles = 0;
      while (nreset !== 1'b1)
      begin
         cycles++;
         assert (cycles < TIMEOUT)
         else
            abort_run("timeout: reset was never released");
         @(posedge clk);
      end
      @(posedge clk);

      for (int r = 0; r < num_recs; r++)
      begin
         send_record(1 + r * REC_WORDS);
      end

      // let the last replies drain through the stalls
      cycles = 0;
      while (expected_q.size() != 0)
      begin
         cycles++;
         assert (cycles < TIMEOUT)
         else
            abort_run("timeout: expected output packets never arrived");
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      assert (!out_valid && expected_q.size() == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
         abort_run("an output packet was still pending at the end of the run");
   end

endmodule

`default_nettype wire
